// File: build.f
source/receiver_pkg.sv
source/uart_rx.sv
source/frame_end_timer.sv
source/at_response_buffer.sv
source/stream_command_decoder.sv
source/receiver_centre.sv
dv/clock_gen.sv
dv/receiver_centre_tb.sv

// File: dv/clock_gen.sv
// testbench clock and reset source for the receiver.
// 8 ns clock; reset is held high for the first two rising edges.
`timescale 1ns/10ps

module clock_gen (
	output logic clock,
	output logic reset
);

	localparam time half_period = 4ns; // 125 mhz.

	initial
	begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0; // released just after the second edge.
	end

endmodule

// File: dv/receiver_cases.txt
# columns (hex): mode drain count b0 b1 b2 b3 b4 b5 b6 b7 select sending words
# mode 1 = at, 0 = data; words = complete words in the buffer after the frame
1 1 4 4f 4b 0d 0a 00 00 00 00 00 0 2
1 1 6 2b 56 45 52 3d 31 00 00 00 0 3
0 0 2 00 05 00 00 00 00 00 00 05 1 0
0 0 2 00 00 00 00 00 00 00 00 00 0 0
0 0 2 00 07 00 00 00 00 00 00 07 1 0
0 0 2 01 00 00 00 00 00 00 00 07 0 0
0 0 2 00 09 00 00 00 00 00 00 09 1 0
0 0 2 5a 33 00 00 00 00 00 00 09 1 0
1 0 8 10 11 12 13 14 15 16 17 09 1 4
1 0 8 18 19 1a 1b 1c 1d 1e 1f 09 1 8
1 0 8 20 21 22 23 24 25 26 27 09 1 c
1 0 8 28 29 2a 2b 2c 2d 2e 2f 09 1 10
0 0 2 01 00 00 00 00 00 00 00 09 0 10
1 0 8 30 31 32 33 34 35 36 37 09 0 14
1 0 8 38 39 3a 3b 3c 3d 3e 3f 09 0 18
1 0 8 40 41 42 43 44 45 46 47 09 0 1c
1 0 8 48 49 4a 4b 4c 4d 4e 4f 09 0 20
1 1 8 e0 e1 e2 e3 e4 e5 e6 e7 09 0 20
1 1 2 4f 4b 00 00 00 00 00 00 09 0 1

// File: dv/receiver_centre_tb.sv
// testbench for the receive side, run from the cases file in dv/.
// each case is one serial frame; counts, words, flags and stream state are checked.
`timescale 1ns/10ps

module receiver_centre_tb;

	localparam int bit_cycles = 8; // serial bit period in clocks.
	localparam int idle_cap = 40; // quiet cycles that end a frame.
	localparam int buffer_bytes = 64; // at buffer capacity.
	localparam int max_cases = 64;
	localparam int frame_wait_limit = 400; // cycles to wait for a frame end.
	localparam string case_path = "dv/receiver_cases.txt";

	logic clock;
	logic reset;
	logic want_at;
	logic rxd;
	logic [9:0] cycles_per_bit;
	logic [9:0] timer_cap;
	logic at_response_flag;
	logic read_enable;
	logic [15:0] read_data;
	logic empty;
	logic full;
	logic [6:0] wr_count;
	logic [5:0] rd_count;
	logic [7:0] stream_select;
	logic sending;
	logic [7:0] command;
	logic [7:0] operand;

	// case table filled from the file.
	int case_mode [max_cases];
	int case_drain [max_cases];
	int case_count [max_cases];
	logic [7:0] case_bytes [max_cases][8];
	int case_select [max_cases];
	int case_sending [max_cases];
	int case_words [max_cases];
	int n_cases = 0;
	bit cases_loaded = 0;

	logic [7:0] model_q [$]; // bytes the buffer should hold, oldest first.
	logic [7:0] exp_command = 8'h00;
	logic [7:0] exp_operand = 8'h00;
	logic [31:0] rand_state = 32'd40; // lcg seed.
	int flag_count = 0; // at_response_flag pulses this frame.
	int errors = 0;
	int checks = 0;

	clock_gen clocks (
		.clock(clock),
		.reset(reset)
	);

	receiver_centre UUT (
		.clock(clock),
		.reset(reset),
		.want_at(want_at),
		.rxd(rxd),
		.cycles_per_bit(cycles_per_bit),
		.timer_cap(timer_cap),
		.at_response_flag(at_response_flag),
		.read_enable(read_enable),
		.read_data(read_data),
		.empty(empty),
		.full(full),
		.wr_count(wr_count),
		.rd_count(rd_count),
		.stream_select(stream_select),
		.sending(sending),
		.command(command),
		.operand(operand)
	);

	function automatic logic [31:0] next_random(input logic [31:0] state);
		next_random = state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("Mismatch %s: got %0h, expected %0h", name, got, expected);
		end
	endtask

	// one 8n1 frame, lsb first, then some idle high cycles.
	task automatic send_byte(input logic [7:0] value, input int gap);
		@(posedge clock);
		#1 rxd = 1'b0; // start bit.
		repeat (bit_cycles) @(posedge clock);
		for (int i = 0; i < 8; i++)
		begin
			#1 rxd = value[i];
			repeat (bit_cycles) @(posedge clock);
		end
		#1 rxd = 1'b1; // stop bit.
		repeat (bit_cycles + gap) @(posedge clock);
	endtask

	// frame_done is internal; it is the only end marker in data mode.
	task automatic wait_frame_end();
		int waited;
		waited = 0;
		@(negedge clock);
		while (UUT.frame_done !== 1'b1 && waited < frame_wait_limit)
		begin
			@(negedge clock);
			waited++;
		end
		if (waited >= frame_wait_limit)
		begin
			errors++;
			$display("frame end was never signalled after %0d cycles", waited);
		end
	endtask

	// pops every complete word and compares it with the byte model.
	task automatic drain_buffer();
		logic [15:0] expected;
		while (model_q.size() >= 2)
		begin
			expected = {model_q[0], model_q[1]}; // first byte is upper.
			check_value("read_data", read_data, expected);
			check_value("empty", empty, 1'b0);
			void'(model_q.pop_front());
			void'(model_q.pop_front());
			@(posedge clock);
			#1 read_enable = 1'b1;
			@(posedge clock);
			#1 read_enable = 1'b0;
			@(negedge clock);
		end
		check_value("empty", empty, 1'b1);
		check_value("rd_count", rd_count, 32'd0);
	endtask

	task automatic run_case(input int idx);
		int n;
		int gap;
		logic [7:0] b;
		n = case_count[idx];
		@(posedge clock);
		#1 want_at = case_mode[idx][0];
		flag_count = 0;
		for (int k = 0; k < n; k++)
		begin
			b = case_bytes[idx][k];
			if (case_mode[idx] != 0)
			begin
				if (model_q.size() < buffer_bytes)
					model_q.push_back(b); // bytes past capacity are lost.
			end
			else if (k % 2 == 0)
				exp_command = b;
			else
				exp_operand = b;
			gap = 0;
			if (k < n - 1)
			begin
				rand_state = next_random(rand_state);
				gap = (rand_state >> 16) % 16;
			end
			send_byte(b, gap);
		end
		wait_frame_end();
		@(negedge clock); // decoder result lands here.
		@(negedge clock);
		check_value("at_response_flag count", flag_count, (case_mode[idx] != 0) ? 1 : 0);
		check_value("wr_count", wr_count, model_q.size());
		check_value("rd_count", rd_count, case_words[idx]);
		check_value("full", full, model_q.size() == buffer_bytes);
		check_value("stream_select", stream_select, case_select[idx]);
		check_value("sending", sending, case_sending[idx]);
		check_value("command", command, exp_command);
		check_value("operand", operand, exp_operand);
		if (case_drain[idx] != 0)
			drain_buffer();
	endtask

	task automatic load_cases();
		int fd;
		int got;
		string line;
		int f [14];
		fd = $fopen(case_path, "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the case file %s", case_path);
			return;
		end
		while (!$feof(fd) && n_cases < max_cases)
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue;
			got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
				f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
			if (got != 14)
				continue; // blank or short line.
			case_mode[n_cases] = f[0];
			case_drain[n_cases] = f[1];
			case_count[n_cases] = (f[2] > 8) ? 8 : f[2];
			for (int k = 0; k < 8; k++)
				case_bytes[n_cases][k] = f[3 + k];
			case_select[n_cases] = f[11];
			case_sending[n_cases] = f[12];
			case_words[n_cases] = f[13];
			n_cases++;
		end
		$fclose(fd);
	endtask

	// counts flag pulses at the falling edge, where outputs are settled.
	always @(negedge clock)
	begin
		if (at_response_flag === 1'b1)
			flag_count++;
	end

	// watchdog budget scales with the number of cases.
	initial
	begin
		wait (cases_loaded);
		repeat (n_cases * (8 * 12 * bit_cycles + 200) + 20) @(posedge clock);
		$display("run timed out before all cases finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		want_at = 1'b0;
		rxd = 1'b1; // line idles high.
		cycles_per_bit = bit_cycles;
		timer_cap = idle_cap;
		read_enable = 1'b0;
		load_cases();
		cases_loaded = 1;
		@(negedge reset);
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_value("empty", empty, 1'b1);
		check_value("sending", sending, 1'b0);
		check_value("stream_select", stream_select, 32'd0);
		for (int i = 0; i < n_cases; i++)
			run_case(i);
		if (n_cases == 0)
		begin
			errors++;
			$display("no cases were read from the case file");
		end
		$display("errors: %0d, checks: %0d, cases: %0d", errors, checks, n_cases);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: source/at_response_buffer.sv
// byte-in, 16-bit-word-out buffer holding at replies for the host.
// read_data shows the oldest full word; read_enable pops it. first byte lands high.
`timescale 1ns/10ps

module at_response_buffer (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                mode_at,
	input  logic [7:0]                          byte_data,
	input  logic                                byte_valid,
	input  logic                                read_enable,
	output logic [15:0]                         read_data,
	output logic                                empty,
	output logic                                full,
	output logic [receiver_pkg::wr_count_width-1:0] wr_count,
	output logic [receiver_pkg::rd_count_width-1:0] rd_count
);
	import receiver_pkg::*;

	logic [7:0] mem [buffer_depth_bytes]; // circular byte store.
	logic [byte_addr_width-1:0] wr_ptr; // next byte slot.
	logic [byte_addr_width-2:0] rd_word_ptr; // oldest word, in words.
	logic [byte_addr_width-1:0] upper_addr;
	logic [byte_addr_width-1:0] lower_addr;
	logic [wr_count_width-1:0] byte_count; // stored bytes.
	logic write_en;
	logic pop_en;

	// with no room the byte is lost since the line cannot wait.
	assign write_en = byte_valid & mode_at & ~full;
	assign pop_en = read_enable & ~empty; // pop on empty is ignored.

	assign full = (byte_count == wr_count_width'(buffer_depth_bytes));
	assign empty = (byte_count < wr_count_width'(2)); // half a word is not readable.
	assign wr_count = byte_count;
	assign rd_count = byte_count[wr_count_width-1:1]; // whole words.

	// word pointer addresses an even/odd byte pair.
	assign upper_addr = {rd_word_ptr, 1'b0};
	assign lower_addr = {rd_word_ptr, 1'b1};
	assign read_data = {mem[upper_addr], mem[lower_addr]}; // fall-through read.

	always_ff @(posedge clock)
	begin
		if (write_en)
			mem[wr_ptr] <= byte_data;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_word_ptr <= '0;
			byte_count <= '0;
		end
		else
		begin
			if (write_en)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
			if (pop_en)
				rd_word_ptr <= rd_word_ptr + 1'b1;
			case ({write_en, pop_en})
				2'b10: byte_count <= byte_count + 1'b1;
				2'b01: byte_count <= byte_count - 2'd2;
				2'b11: byte_count <= byte_count - 1'b1; // one in, two out.
				default: byte_count <= byte_count;
			endcase
		end
	end

endmodule

// File: source/frame_end_timer.sv
// idle timer that decides a frame is over.
// after a byte it counts quiet cycles; frame_done pulses when timer_cap is hit.
`timescale 1ns/10ps

module frame_end_timer (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  byte_valid,
	input  logic                                  collecting,
	input  logic [receiver_pkg::bit_period_width-1:0] timer_cap,
	output logic                                  frame_done
);
	import receiver_pkg::*;

	typedef enum logic [1:0] {
		waiting,
		checking,
		done
	} timer_state_t;

	timer_state_t state;
	logic [bit_period_width-1:0] count; // quiet cycles so far.

	assign frame_done = (state == done);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= waiting;
			count <= '0;
		end
		else
		begin
			case (state)
				waiting:
				begin
					count <= '0;
					if (byte_valid)
						state <= checking; // a byte just landed.
				end
				checking:
				begin
					if (collecting)
					begin
						count <= '0;
						state <= waiting; // next byte started, not the end.
					end
					else if (count == timer_cap)
					begin
						count <= '0;
						state <= done;
					end
					else
						count <= count + 1'b1;
				end
				done:
				begin
					count <= '0;
					state <= waiting; // one cycle only.
				end
				default: state <= waiting;
			endcase
		end
	end

endmodule

// File: source/receiver_centre.sv
// receive side top level: uart, frame timer, at buffer and stream decoder.
// want_at picks which side consumes the incoming frames.
`timescale 1ns/10ps

module receiver_centre (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  want_at,
	input  logic                                  rxd,
	input  logic [receiver_pkg::bit_period_width-1:0] cycles_per_bit,
	input  logic [receiver_pkg::bit_period_width-1:0] timer_cap,
	output logic                                  at_response_flag,
	input  logic                                  read_enable,
	output logic [15:0]                           read_data,
	output logic                                  empty,
	output logic                                  full,
	output logic [receiver_pkg::wr_count_width-1:0]   wr_count,
	output logic [receiver_pkg::rd_count_width-1:0]   rd_count,
	output logic [7:0]                            stream_select,
	output logic                                  sending,
	output logic [7:0]                            command,
	output logic [7:0]                            operand
);

	logic [7:0] byte_data; // received byte.
	logic byte_valid;
	logic collecting; // uart mid-byte.
	logic frame_done;

	// frame end only counts as an at reply in at mode.
	assign at_response_flag = frame_done & want_at;

	uart_rx rx (
		.clock(clock),
		.reset(reset),
		.cycles_per_bit(cycles_per_bit),
		.rx_line(rxd),
		.byte_data(byte_data),
		.byte_valid(byte_valid),
		.collecting(collecting)
	);

	frame_end_timer end_timer (
		.clock(clock),
		.reset(reset),
		.byte_valid(byte_valid),
		.collecting(collecting),
		.timer_cap(timer_cap),
		.frame_done(frame_done)
	);

	at_response_buffer at_buffer (
		.clock(clock),
		.reset(reset),
		.mode_at(want_at),
		.byte_data(byte_data),
		.byte_valid(byte_valid),
		.read_enable(read_enable),
		.read_data(read_data),
		.empty(empty),
		.full(full),
		.wr_count(wr_count),
		.rd_count(rd_count)
	);

	stream_command_decoder decoder (
		.clock(clock),
		.reset(reset),
		.mode_at(want_at),
		.byte_data(byte_data),
		.byte_valid(byte_valid),
		.frame_done(frame_done),
		.command(command),
		.operand(operand),
		.stream_select(stream_select),
		.sending(sending)
	);

endmodule

// File: source/receiver_pkg.sv
// shared constants for the bluetooth receive path.
// imported by the receiver modules; the top level uses scoped names only.
package receiver_pkg;

	// at reply buffer sizing.
	localparam int buffer_depth_bytes = 64; // byte capacity.
	localparam int byte_addr_width = $clog2(buffer_depth_bytes); // byte address bits.

	// occupancy counts.
	localparam int wr_count_width = 7; // holds 0 to 64 bytes.
	localparam int rd_count_width = 6; // complete 16-bit words.

	// cycles-per-bit and idle timer cap share one width.
	localparam int bit_period_width = 10;

	// data mode command bytes.
	localparam logic [7:0] cmd_start = 8'h00; // select a stream.
	localparam logic [7:0] cmd_cancel = 8'h01; // stop sending.

endpackage

// File: source/stream_command_decoder.sv
// data mode command path; bytes pair up as command then operand.
// at frame end the pair picks a stream or stops sending.
`timescale 1ns/10ps

module stream_command_decoder (
	input  logic       clock,
	input  logic       reset,
	input  logic       mode_at,
	input  logic [7:0] byte_data,
	input  logic       byte_valid,
	input  logic       frame_done,
	output logic [7:0] command,
	output logic [7:0] operand,
	output logic [7:0] stream_select,
	output logic       sending
);
	import receiver_pkg::*;

	logic got_one; // command stored, operand next.
	logic take_byte;
	logic interpret;

	assign take_byte = byte_valid & ~mode_at;
	assign interpret = frame_done & ~mode_at;

	// pairing plus the two capture registers.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			got_one <= 1'b0;
			command <= 8'h00;
			operand <= 8'h00;
		end
		else if (frame_done)
			got_one <= 1'b0; // every frame starts on a command byte.
		else if (take_byte)
		begin
			if (got_one)
				operand <= byte_data;
			else
				command <= byte_data;
			got_one <= ~got_one;
		end
	end

	// applied one cycle after the frame ends.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			stream_select <= 8'h00;
			sending <= 1'b0;
		end
		else if (interpret)
		begin
			case (command)
				cmd_start:
				begin
					stream_select <= operand; // zero operand means stop all.
					sending <= (operand != 8'h00);
				end
				cmd_cancel: sending <= 1'b0; // keeps the last stream.
				default: ; // unknown commands change nothing.
			endcase
		end
	end

endmodule

// File: source/uart_rx.sv
// serial-to-byte receiver for the radio module line, 8n1, lsb first.
// cycles_per_bit sets the bit period; byte_valid pulses at mid stop bit.
`timescale 1ns/10ps

module uart_rx (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic [receiver_pkg::bit_period_width-1:0] cycles_per_bit,
	input  logic                                  rx_line,
	output logic [7:0]                            byte_data,
	output logic                                  byte_valid,
	output logic                                  collecting
);
	import receiver_pkg::*;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	rx_state_t state;
	logic line_meta; // first sync stage.
	logic line_sync; // second sync stage, safe to use.
	logic [bit_period_width-1:0] count; // cycles into the current bit.
	logic [bit_period_width-1:0] half_period;
	logic [bit_period_width-1:0] last_count;
	logic [2:0] bit_index; // data bit being collected.
	logic [7:0] shift; // assembles the byte.
	logic half_tick;
	logic bit_tick;

	assign half_period = cycles_per_bit >> 1;
	assign last_count = cycles_per_bit - 1'b1;
	assign half_tick = (count == half_period); // middle of start bit.
	assign bit_tick = (count == last_count); // one full period later.

	// busy from start edge until the stop bit is sampled.
	assign collecting = (state != rx_idle);
	assign byte_data = shift;

	// line idles high.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			line_meta <= 1'b1;
			line_sync <= 1'b1;
		end
		else
		begin
			line_meta <= rx_line;
			line_sync <= line_meta;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= rx_idle;
			count <= '0;
			bit_index <= '0;
			byte_valid <= 1'b0;
		end
		else
		begin
			byte_valid <= 1'b0; // single cycle pulse.
			case (state)
				rx_idle:
				begin
					count <= '0;
					bit_index <= '0;
					if (!line_sync)
						state <= rx_start; // falling edge seen.
				end
				rx_start:
				begin
					if (half_tick)
					begin
						count <= '0;
						// a start bit that is no longer low was a glitch.
						state <= line_sync ? rx_idle : rx_data;
					end
					else
						count <= count + 1'b1;
				end
				rx_data:
				begin
					if (bit_tick)
					begin
						count <= '0;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7)
							state <= rx_stop; // eighth bit taken.
					end
					else
						count <= count + 1'b1;
				end
				rx_stop:
				begin
					if (bit_tick)
					begin
						count <= '0;
						state <= rx_idle;
						byte_valid <= line_sync; // low stop bit drops the byte.
					end
					else
						count <= count + 1'b1;
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// data bits shift in from the top so the lsb ends up in bit 0.
	always_ff @(posedge clock)
	begin
		if (state == rx_data && bit_tick)
			shift <= {line_sync, shift[7:1]};
	end

endmodule
